/* common/systolic_pkg.sv */
`default_nettype none

package systolic_pkg;

    // element and accumulator widths
    localparam int DATA_WIDTH   = 8;
    localparam int ACC_WIDTH    = 2 * DATA_WIDTH;

    // operand buffer depth, one entry per inner step
    localparam int K_ADDR_WIDTH = 6;
    localparam int K_MAX        = 1 << K_ADDR_WIDTH;

    typedef logic [DATA_WIDTH-1:0]   elem_t;
    typedef logic [ACC_WIDTH-1:0]    acc_t;
    typedef logic [K_ADDR_WIDTH-1:0] k_addr_t;

    // one extra bit so that n = K_MAX fits
    typedef logic [K_ADDR_WIDTH:0]   k_len_t;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        FEED,
        DRAIN,
        UNLOAD
    } seq_state_t;

endpackage

`default_nettype wire

/* src/operand_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_buffer #(
    parameter int LANES = 4
) (
    input  wire                                  clk,
    input  wire                                  wr_en_i,
    input  wire systolic_pkg::k_addr_t           wr_addr_i,
    input  wire systolic_pkg::elem_t [LANES-1:0] wr_data_i,
    input  wire systolic_pkg::k_addr_t           rd_addr_i,
    output systolic_pkg::elem_t [LANES-1:0]      rd_data_o
);
    import systolic_pkg::*;

    // one lane vector per inner step
    elem_t [LANES-1:0] mem [K_MAX];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

/* src/feed_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module feed_sequencer #(
    parameter int ARRAY_HEIGHT = 4,
    parameter int ARRAY_WIDTH  = 4
) (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire                         start_i,
    input  wire systolic_pkg::k_len_t   n_i,
    input  wire                         unload_done_i,
    output systolic_pkg::k_addr_t       rd_addr_o,
    output logic                        feed_valid_o,
    output logic                        clear_o,
    output logic                        unload_start_o,
    output logic                        busy_o
);
    import systolic_pkg::*;

    // enough cycles for the last product to cross the skew and the grid
    localparam int DRAIN_CYCLES = ARRAY_HEIGHT + ARRAY_WIDTH + 1;
    localparam int DRAIN_W      = $clog2(DRAIN_CYCLES);

    seq_state_t         state_q;
    k_len_t             n_q;
    k_addr_t            step_q;
    logic [DRAIN_W-1:0] drain_q;
    logic               done_tail_q;
    logic               start_ok;
    logic               last_step;
    logic               last_drain;

    assign start_ok   = start_i && !busy_o;
    assign last_step  = (k_len_t'(step_q) == n_q - k_len_t'(1));
    assign last_drain = (drain_q == DRAIN_W'(DRAIN_CYCLES - 1));

    assign rd_addr_o  = step_q;
    assign clear_o    = (state_q == CLEAR);
    // stays up through the done_o cycle
    assign busy_o     = (state_q != IDLE) || done_tail_q;

    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_ok) begin
            n_q <= n_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= IDLE;
            step_q  <= '0;
            drain_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_ok) begin
                        state_q <= CLEAR;
                    end
                end
                CLEAR: begin
                    step_q  <= '0;
                    drain_q <= '0;
                    // empty inner length skips straight to the drain
                    state_q <= (n_q == '0) ? DRAIN : FEED;
                end
                FEED: begin
                    if (last_step) begin
                        state_q <= DRAIN;
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                DRAIN: begin
                    if (last_drain) begin
                        state_q <= UNLOAD;
                    end else begin
                        drain_q <= drain_q + 1'b1;
                    end
                end
                UNLOAD: begin
                    if (unload_done_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // pulses, feed_valid lines up with the buffer read data
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            feed_valid_o   <= 1'b0;
            unload_start_o <= 1'b0;
            done_tail_q    <= 1'b0;
        end else begin
            feed_valid_o   <= (state_q == FEED);
            unload_start_o <= (state_q == DRAIN) && last_drain;
            done_tail_q    <= (state_q == UNLOAD) && unload_done_i;
        end
    end

endmodule

`default_nettype wire

/* src/skew_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module skew_stage #(
    parameter int ARRAY_HEIGHT = 4,
    parameter int ARRAY_WIDTH  = 4
) (
    input  wire                                         clk,
    input  wire                                         reset_n,
    input  wire                                         valid_i,
    input  wire systolic_pkg::elem_t [ARRAY_HEIGHT-1:0] a_lanes_i,
    input  wire systolic_pkg::elem_t [ARRAY_WIDTH-1:0]  b_lanes_i,
    output systolic_pkg::elem_t [ARRAY_HEIGHT-1:0]      a_lanes_o,
    output systolic_pkg::elem_t [ARRAY_WIDTH-1:0]       b_lanes_o,
    output logic [ARRAY_HEIGHT-1:0]                     a_valid_o,
    output logic [ARRAY_WIDTH-1:0]                      b_valid_o
);
    import systolic_pkg::*;

    localparam int LANES = ARRAY_HEIGHT + ARRAY_WIDTH;

    // a lanes in the low slots, b lanes above them
    elem_t [LANES-1:0] lane_in;
    elem_t [LANES-1:0] lane_out;
    logic  [LANES-1:0] vld_out;

    assign lane_in   = {b_lanes_i, a_lanes_i};
    assign a_lanes_o = lane_out[ARRAY_HEIGHT-1:0];
    assign b_lanes_o = lane_out[LANES-1:ARRAY_HEIGHT];
    assign a_valid_o = vld_out[ARRAY_HEIGHT-1:0];
    assign b_valid_o = vld_out[LANES-1:ARRAY_HEIGHT];

    for (genvar j = 0; j < LANES; j++) begin : g_lane
        localparam int DEPTH = (j < ARRAY_HEIGHT) ? j : j - ARRAY_HEIGHT;

        if (DEPTH == 0) begin : g_direct
            assign lane_out[j] = lane_in[j];
            assign vld_out[j]  = valid_i;
        end else begin : g_delay
            elem_t            data_sr [DEPTH];
            logic [DEPTH-1:0] vld_sr;

            always_ff @(posedge clk) begin
                data_sr[0] <= lane_in[j];
                for (int i = 1; i < DEPTH; i++) begin
                    data_sr[i] <= data_sr[i-1];
                end
            end

            always_ff @(posedge clk or negedge reset_n) begin
                if (!reset_n) begin
                    vld_sr <= '0;
                end else begin
                    vld_sr[0] <= valid_i;
                    for (int i = 1; i < DEPTH; i++) begin
                        vld_sr[i] <= vld_sr[i-1];
                    end
                end
            end

            assign lane_out[j] = data_sr[DEPTH-1];
            assign vld_out[j]  = vld_sr[DEPTH-1];
        end
    end

endmodule

`default_nettype wire

/* pe_array/pe_cell.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_cell (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire                         clear_i,
    input  wire systolic_pkg::elem_t    a_i,
    input  wire                         a_valid_i,
    input  wire systolic_pkg::elem_t    b_i,
    input  wire                         b_valid_i,
    output systolic_pkg::elem_t         a_o,
    output logic                        a_valid_o,
    output systolic_pkg::elem_t         b_o,
    output logic                        b_valid_o,
    output systolic_pkg::acc_t          acc_o
);
    import systolic_pkg::*;

    // operands move one cell per cycle
    always_ff @(posedge clk) begin
        a_o <= a_i;
        b_o <= b_i;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            a_valid_o <= 1'b0;
            b_valid_o <= 1'b0;
        end else begin
            a_valid_o <= a_valid_i;
            b_valid_o <= b_valid_i;
        end
    end

    // wraps modulo 2**ACC_WIDTH
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            acc_o <= '0;
        end else if (clear_i) begin
            acc_o <= '0;
        end else if (a_valid_i && b_valid_i) begin
            acc_o <= acc_o + acc_t'(a_i) * acc_t'(b_i);
        end
    end

endmodule

`default_nettype wire

/* pe_array/pe_array.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_array #(
    parameter int ARRAY_HEIGHT = 4,
    parameter int ARRAY_WIDTH  = 4
) (
    input  wire                                         clk,
    input  wire                                         reset_n,
    input  wire                                         clear_i,
    input  wire systolic_pkg::elem_t [ARRAY_HEIGHT-1:0] a_lanes_i,
    input  wire [ARRAY_HEIGHT-1:0]                      a_valid_i,
    input  wire systolic_pkg::elem_t [ARRAY_WIDTH-1:0]  b_lanes_i,
    input  wire [ARRAY_WIDTH-1:0]                       b_valid_i,
    output systolic_pkg::acc_t [ARRAY_HEIGHT*ARRAY_WIDTH-1:0] acc_grid_o
);
    import systolic_pkg::*;

    // a runs left to right along a row, b top to bottom along a column
    elem_t a_fwd [ARRAY_HEIGHT][ARRAY_WIDTH+1];
    logic  a_vld [ARRAY_HEIGHT][ARRAY_WIDTH+1];
    elem_t b_fwd [ARRAY_HEIGHT+1][ARRAY_WIDTH];
    logic  b_vld [ARRAY_HEIGHT+1][ARRAY_WIDTH];

    // left edge
    for (genvar r = 0; r < ARRAY_HEIGHT; r++) begin : g_left
        assign a_fwd[r][0] = a_lanes_i[r];
        assign a_vld[r][0] = a_valid_i[r];
    end

    // top edge
    for (genvar c = 0; c < ARRAY_WIDTH; c++) begin : g_top
        assign b_fwd[0][c] = b_lanes_i[c];
        assign b_vld[0][c] = b_valid_i[c];
    end

    for (genvar r = 0; r < ARRAY_HEIGHT; r++) begin : g_row
        for (genvar c = 0; c < ARRAY_WIDTH; c++) begin : g_col
            pe_cell u_pe_cell (
                .clk       (clk),
                .reset_n   (reset_n),
                .clear_i   (clear_i),
                .a_i       (a_fwd[r][c]),
                .a_valid_i (a_vld[r][c]),
                .b_i       (b_fwd[r][c]),
                .b_valid_i (b_vld[r][c]),
                .a_o       (a_fwd[r][c+1]),
                .a_valid_o (a_vld[r][c+1]),
                .b_o       (b_fwd[r+1][c]),
                .b_valid_o (b_vld[r+1][c]),
                // row-major flat index
                .acc_o     (acc_grid_o[r*ARRAY_WIDTH + c])
            );
        end
    end

endmodule

`default_nettype wire

/* src/result_unloader.sv */
`timescale 1ns/1ps
`default_nettype none

module result_unloader #(
    parameter int ARRAY_HEIGHT = 4,
    parameter int ARRAY_WIDTH  = 4
) (
    input  wire                                     clk,
    input  wire                                     reset_n,
    input  wire                                     unload_start_i,
    input  wire systolic_pkg::acc_t [ARRAY_HEIGHT*ARRAY_WIDTH-1:0] acc_grid_i,
    output logic                                    c_valid_o,
    output logic [$clog2(ARRAY_HEIGHT)-1:0]         c_row_idx_o,
    output systolic_pkg::acc_t [ARRAY_WIDTH-1:0]    c_row_o,
    output logic                                    done_o,
    output logic                                    unload_done_o
);
    import systolic_pkg::*;

    localparam int ROW_W = $clog2(ARRAY_HEIGHT);

    acc_t [ARRAY_WIDTH-1:0] row_q [ARRAY_HEIGHT];
    logic                   last_row;

    assign last_row      = (c_row_idx_o == ROW_W'(ARRAY_HEIGHT - 1));
    assign unload_done_o = c_valid_o && last_row;
    assign c_row_o       = row_q[c_row_idx_o];

    // snapshot the whole grid, the array may be cleared afterwards
    always_ff @(posedge clk) begin
        if (unload_start_i) begin
            for (int r = 0; r < ARRAY_HEIGHT; r++) begin
                row_q[r] <= acc_grid_i[r*ARRAY_WIDTH +: ARRAY_WIDTH];
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            c_valid_o   <= 1'b0;
            c_row_idx_o <= '0;
            done_o      <= 1'b0;
        end else begin
            done_o <= unload_done_o;
            if (unload_start_i) begin
                c_valid_o   <= 1'b1;
                c_row_idx_o <= '0;
            end else if (c_valid_o) begin
                if (last_row) begin
                    c_valid_o <= 1'b0;
                end else begin
                    c_row_idx_o <= c_row_idx_o + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/matmul_top.sv */
`timescale 1ns/1ps
`default_nettype none

module matmul_top #(
    parameter int ARRAY_HEIGHT = 4,
    parameter int ARRAY_WIDTH  = 4
) (
    input  wire                                         clk,
    input  wire                                         reset_n,
    input  wire                                         a_wr_en_i,
    input  wire systolic_pkg::k_addr_t                  a_wr_addr_i,
    input  wire systolic_pkg::elem_t [ARRAY_HEIGHT-1:0] a_wr_data_i,
    input  wire                                         b_wr_en_i,
    input  wire systolic_pkg::k_addr_t                  b_wr_addr_i,
    input  wire systolic_pkg::elem_t [ARRAY_WIDTH-1:0]  b_wr_data_i,
    input  wire                                         start_i,
    input  wire systolic_pkg::k_len_t                   n_i,
    output logic                                        busy_o,
    output logic                                        c_valid_o,
    output logic [$clog2(ARRAY_HEIGHT)-1:0]             c_row_idx_o,
    output systolic_pkg::acc_t [ARRAY_WIDTH-1:0]        c_row_o,
    output logic                                        done_o
);
    import systolic_pkg::*;

    k_addr_t                                rd_addr;
    elem_t [ARRAY_HEIGHT-1:0]               a_rd_data;
    elem_t [ARRAY_WIDTH-1:0]                b_rd_data;
    logic                                   feed_valid;
    logic                                   clear;
    logic                                   unload_start;
    logic                                   unload_done;
    elem_t [ARRAY_HEIGHT-1:0]               a_skew;
    elem_t [ARRAY_WIDTH-1:0]                b_skew;
    logic  [ARRAY_HEIGHT-1:0]               a_skew_valid;
    logic  [ARRAY_WIDTH-1:0]                b_skew_valid;
    acc_t  [ARRAY_HEIGHT*ARRAY_WIDTH-1:0]   acc_grid;

    operand_buffer #(.LANES(ARRAY_HEIGHT)) u_a_buffer (
        .clk       (clk),
        .wr_en_i   (a_wr_en_i),
        .wr_addr_i (a_wr_addr_i),
        .wr_data_i (a_wr_data_i),
        .rd_addr_i (rd_addr),
        .rd_data_o (a_rd_data)
    );

    operand_buffer #(.LANES(ARRAY_WIDTH)) u_b_buffer (
        .clk       (clk),
        .wr_en_i   (b_wr_en_i),
        .wr_addr_i (b_wr_addr_i),
        .wr_data_i (b_wr_data_i),
        .rd_addr_i (rd_addr),
        .rd_data_o (b_rd_data)
    );

    feed_sequencer #(
        .ARRAY_HEIGHT (ARRAY_HEIGHT),
        .ARRAY_WIDTH  (ARRAY_WIDTH)
    ) u_feed_sequencer (
        .clk            (clk),
        .reset_n        (reset_n),
        .start_i        (start_i),
        .n_i            (n_i),
        .unload_done_i  (unload_done),
        .rd_addr_o      (rd_addr),
        .feed_valid_o   (feed_valid),
        .clear_o        (clear),
        .unload_start_o (unload_start),
        .busy_o         (busy_o)
    );

    skew_stage #(
        .ARRAY_HEIGHT (ARRAY_HEIGHT),
        .ARRAY_WIDTH  (ARRAY_WIDTH)
    ) u_skew_stage (
        .clk       (clk),
        .reset_n   (reset_n),
        .valid_i   (feed_valid),
        .a_lanes_i (a_rd_data),
        .b_lanes_i (b_rd_data),
        .a_lanes_o (a_skew),
        .b_lanes_o (b_skew),
        .a_valid_o (a_skew_valid),
        .b_valid_o (b_skew_valid)
    );

    pe_array #(
        .ARRAY_HEIGHT (ARRAY_HEIGHT),
        .ARRAY_WIDTH  (ARRAY_WIDTH)
    ) u_pe_array (
        .clk        (clk),
        .reset_n    (reset_n),
        .clear_i    (clear),
        .a_lanes_i  (a_skew),
        .a_valid_i  (a_skew_valid),
        .b_lanes_i  (b_skew),
        .b_valid_i  (b_skew_valid),
        .acc_grid_o (acc_grid)
    );

    result_unloader #(
        .ARRAY_HEIGHT (ARRAY_HEIGHT),
        .ARRAY_WIDTH  (ARRAY_WIDTH)
    ) u_result_unloader (
        .clk            (clk),
        .reset_n        (reset_n),
        .unload_start_i (unload_start),
        .acc_grid_i     (acc_grid),
        .c_valid_o      (c_valid_o),
        .c_row_idx_o    (c_row_idx_o),
        .c_row_o        (c_row_o),
        .done_o         (done_o),
        .unload_done_o  (unload_done)
    );

endmodule

`default_nettype wire

/* verification/tb_matmul.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_matmul;
    import systolic_pkg::*;

    localparam int ARRAY_HEIGHT   = 4;
    localparam int ARRAY_WIDTH    = 4;
    localparam int ROW_W          = $clog2(ARRAY_HEIGHT);
    localparam int LAT_EXTRA      = ARRAY_HEIGHT + ARRAY_WIDTH + 4;
    localparam int NUM_RUNS       = 4;
    localparam int LOAD_CYCLES    = 2 * (K_MAX + 2) + 16;
    localparam int TIMEOUT_CYCLES =
        NUM_RUNS * (K_MAX + 2 * ARRAY_HEIGHT + ARRAY_WIDTH + 20) + LOAD_CYCLES;

    typedef logic [ROW_W-1:0] row_idx_t;

    logic                       clk;
    logic                       reset_n;
    logic                       a_wr_en_i;
    k_addr_t                    a_wr_addr_i;
    elem_t [ARRAY_HEIGHT-1:0]   a_wr_data_i;
    logic                       b_wr_en_i;
    k_addr_t                    b_wr_addr_i;
    elem_t [ARRAY_WIDTH-1:0]    b_wr_data_i;
    logic                       start_i;
    k_len_t                     n_i;
    logic                       busy_o;
    logic                       c_valid_o;
    row_idx_t                   c_row_idx_o;
    acc_t [ARRAY_WIDTH-1:0]     c_row_o;
    logic                       done_o;

    // testbench copies of the buffer contents
    elem_t a_ref [K_MAX][ARRAY_HEIGHT];
    elem_t b_ref [K_MAX][ARRAY_WIDTH];

    logic [31:0] rng_state;
    int          cycle_cnt      = 0;
    int          exp_n          = 0;
    bit          start_pending  = 1'b0;
    bit          in_run         = 1'b0;
    int          start_cycle    = 0;
    int          rows_seen      = 0;
    int          last_row_cycle = 0;
    int          runs_done      = 0;

    matmul_top #(
        .ARRAY_HEIGHT (ARRAY_HEIGHT),
        .ARRAY_WIDTH  (ARRAY_WIDTH)
    ) u_matmul_top (
        .clk         (clk),
        .reset_n     (reset_n),
        .a_wr_en_i   (a_wr_en_i),
        .a_wr_addr_i (a_wr_addr_i),
        .a_wr_data_i (a_wr_data_i),
        .b_wr_en_i   (b_wr_en_i),
        .b_wr_addr_i (b_wr_addr_i),
        .b_wr_data_i (b_wr_data_i),
        .start_i     (start_i),
        .n_i         (n_i),
        .busy_o      (busy_o),
        .c_valid_o   (c_valid_o),
        .c_row_idx_o (c_row_idx_o),
        .c_row_o     (c_row_o),
        .done_o      (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // full precision sum over k < n of A[r][k] * B[k][c], reduced modulo 2**ACC_WIDTH
    function automatic acc_t ref_elem(input int r, input int c, input int n);
        longint sum;
        sum = 0;
        for (int k = 0; k < n; k++) begin
            sum = sum + longint'(a_ref[k][r]) * longint'(b_ref[k][c]);
        end
        return acc_t'(sum % (longint'(1) << ACC_WIDTH));
    endfunction

    task automatic report_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_acc(input acc_t got, input acc_t exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s got %0h expected %0h", what, got, exp));
        end
    endtask

    task automatic check_row_idx(input row_idx_t got, input row_idx_t exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s got %0d expected %0d", what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            report_error($sformatf("%s got %0d expected %0d", what, got, exp));
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    // fill every buffer entry with random or all-ones data
    task automatic load_operands(input bit all_max);
        elem_t v;
        for (int k = 0; k < K_MAX; k++) begin
            @(negedge clk);
            a_wr_en_i   = 1'b1;
            b_wr_en_i   = 1'b1;
            a_wr_addr_i = k_addr_t'(k);
            b_wr_addr_i = k_addr_t'(k);
            for (int r = 0; r < ARRAY_HEIGHT; r++) begin
                rng_state = xorshift32(rng_state);
                v = all_max ? elem_t'('1) : rng_state[DATA_WIDTH-1:0];
                a_wr_data_i[r] = v;
                a_ref[k][r]    = v;
            end
            for (int c = 0; c < ARRAY_WIDTH; c++) begin
                rng_state = xorshift32(rng_state);
                v = all_max ? elem_t'('1) : rng_state[DATA_WIDTH-1:0];
                b_wr_data_i[c] = v;
                b_ref[k][c]    = v;
            end
        end
        @(negedge clk);
        a_wr_en_i = 1'b0;
        b_wr_en_i = 1'b0;
    endtask

    task automatic run_product(input int n, input bit extra_start);
        int prev;
        prev = runs_done;
        @(negedge clk);
        start_i       = 1'b1;
        n_i           = k_len_t'(n);
        exp_n         = n;
        start_pending = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
        if (extra_start) begin
            // a second pulse while busy carries a different length
            repeat (3) @(negedge clk);
            start_i = 1'b1;
            n_i     = k_len_t'(n + 4);
            @(negedge clk);
            start_i = 1'b0;
        end
        while (runs_done == prev) begin
            @(posedge clk);
        end
        @(negedge clk);
        check_level(busy_o, 1'b0, "busy_o after done_o");
        repeat (8) @(negedge clk);
    endtask

    // compare process samples on the rising edge
    always @(posedge clk) begin
        if (reset_n) begin
            if (in_run) begin
                check_level(busy_o, 1'b1, "busy_o during run");
            end
            if (c_valid_o) begin
                if (!in_run) begin
                    report_error("row output appeared with no run in progress");
                end
                if (rows_seen >= ARRAY_HEIGHT) begin
                    report_error("more rows than the array height in one run");
                end
                if (rows_seen == 0) begin
                    check_count(cycle_cnt - start_cycle, exp_n + LAT_EXTRA, "first row latency");
                end else begin
                    check_count(cycle_cnt - last_row_cycle, 1, "cycles between rows");
                end
                check_row_idx(c_row_idx_o, row_idx_t'(rows_seen), "row index");
                for (int c = 0; c < ARRAY_WIDTH; c++) begin
                    check_acc(c_row_o[c], ref_elem(rows_seen, c, exp_n),
                              $sformatf("C[%0d][%0d] n=%0d", rows_seen, c, exp_n));
                end
                rows_seen      <= rows_seen + 1;
                last_row_cycle <= cycle_cnt;
            end
            if (done_o) begin
                if (!in_run) begin
                    report_error("done_o pulsed with no run in progress");
                end
                check_count(rows_seen, ARRAY_HEIGHT, "rows before done_o");
                check_count(cycle_cnt - last_row_cycle, 1, "done_o delay after last row");
                in_run    <= 1'b0;
                runs_done <= runs_done + 1;
            end
            if (start_i && start_pending) begin
                start_cycle   <= cycle_cnt;
                rows_seen     <= 0;
                in_run        <= 1'b1;
                start_pending <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        reset_n     = 1'b0;
        a_wr_en_i   = 1'b0;
        a_wr_addr_i = '0;
        a_wr_data_i = '0;
        b_wr_en_i   = 1'b0;
        b_wr_addr_i = '0;
        b_wr_data_i = '0;
        start_i     = 1'b0;
        n_i         = '0;
        rng_state   = 32'd11;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        load_operands(1'b0);
        run_product(8, 1'b0);
        // same buffers and a shorter length, so no sum from the n = 8 run may remain
        run_product(1, 1'b0);
        run_product(5, 1'b1);

        load_operands(1'b1);
        run_product(K_MAX, 1'b0);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
common/systolic_pkg.sv
src/operand_buffer.sv
src/feed_sequencer.sv
src/skew_stage.sv
pe_array/pe_cell.sv
pe_array/pe_array.sv
src/result_unloader.sv
src/matmul_top.sv
verification/tb_matmul.sv

/* run_sim.sh */
#!/bin/sh
# build and run the matmul testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    -f flist.f \
    --top-module tb_matmul \
    -o Vtb_matmul

./obj_dir/Vtb_matmul 2>&1 | tee sim.log

if grep -qx "Simulation PASSED" sim.log; then
    echo "run_sim: pass"
    exit 0
else
    echo "run_sim: fail"
    exit 1
fi
